//--- vlog.f
hdl/cache_pkg.sv
hdl/cache_data.sv
hdl/cache_tags.sv
hdl/cache_ctrl.sv
hdl/cache_top.sv
bench/cache_tb.sv

//--- bench/cache_tb.sv
// data cache testbench
// memory model, reference cache model, directed and random requests

`timescale 1ns/1ps

module cache_tb import cache_pkg::*; ();

  logic      clk;
  logic      reset;
  logic      cachereq_val;
  logic      cachereq_rdy;
  req_type_t cachereq_type;
  addr_t     cachereq_addr;
  word_t     cachereq_data;
  logic      cacheresp_val;
  logic      cacheresp_rdy;
  word_t     cacheresp_data;
  logic      memreq_val;
  logic      memreq_rdy;
  req_type_t memreq_type;
  addr_t     memreq_addr;
  line_t     memreq_data;
  logic      memresp_val;
  logic      memresp_rdy;
  line_t     memresp_data;
  cnt_t      cnt_req;
  cnt_t      cnt_miss;

  logic [31:0] lfsr = 32'h4433_32bd;
  int          value_errors = 0;
  int          other_errors = 0;
  logic        stall = 1'b0;

  // reference model state
  tag_t        m_tag   [2][8];
  logic        m_valid [2][8];
  logic        m_dirty [2][8];
  line_t       m_line  [2][8];
  logic [7:0]  m_lru;
  line_t       ref_mem [64];
  line_t       mem     [64];
  cnt_t        model_req = '0;
  cnt_t        model_miss = '0;

  // expected responses and memory requests, in order
  word_t       exp_word [$];
  logic        exp_hit  [$];
  req_type_t   mop_type [$];
  addr_t       mop_addr [$];
  line_t       mop_line [$];

  cache_top cache_top_i (.*);

  always #2 clk = ~clk;

  // ------------------------------
  // helpers
  // ------------------------------
  function automatic logic [31:0] take(input int n);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < n; k++) begin
      v = {v[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
    end
    return v;
  endfunction

  function automatic logic random_bit();
    logic [31:0] v;
    v = take(1);
    return v[0];
  endfunction

  // initial memory contents
  function automatic line_t fill_line(input int line);
    line_t  l;
    addr_t  a;
    for (int k = 0; k < 4; k++) begin
      a = addr_t'(line * 16 + k * 4);
      l[32*k +: 32] = a ^ {a[15:0], a[31:16]} ^ 32'h6b1d_e24f;
    end
    return l;
  endfunction

  task automatic flag_error(input string msg);
    $display("error: %s", msg);
    other_errors++;
  endtask

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("FAIL %s got %h expected %h", name, got, exp);
      value_errors++;
    end
  endtask

  task automatic check_addr(input string name, input addr_t got, input addr_t exp);
    if (got !== exp) begin
      $display("FAIL %s got %h expected %h", name, got, exp);
      value_errors++;
    end
  endtask

  task automatic check_cnt(input string name, input cnt_t got, input cnt_t exp);
    if (got !== exp) begin
      $display("FAIL %s got %h expected %h", name, got, exp);
      value_errors++;
    end
  endtask

  task automatic check_line(input string name, input line_t got, input line_t exp);
    if (got !== exp) begin
      $display("FAIL %s got %h expected %h", name, got, exp);
      value_errors++;
    end
  endtask

  // ------------------------------
  // reference cache model
  // ------------------------------
  function automatic void model_access(input req_type_t t, input addr_t a, input word_t d);
    logic [2:0] i;
    logic [1:0] ws;
    tag_t       tg;
    way_t       w;
    logic       hit;
    addr_t      ev;
    i  = a[6:4];
    ws = a[3:2];
    tg = a[31:7];
    w  = way_t'(m_lru[i]);
    hit = 1'b0;
    model_req++;
    for (int k = 0; k < 2; k++) begin
      if (m_valid[k][i] && m_tag[k][i] == tg) begin
        hit = 1'b1;
        w = way_t'(k);
      end
    end
    if (!hit) begin
      model_miss++;
      // dirty victim goes back to memory before the refill
      if (m_valid[w][i] && m_dirty[w][i]) begin
        ev = {m_tag[w][i], i, 4'b0000};
        ref_mem[ev[9:4]] = m_line[w][i];
        mop_type.push_back(req_write);
        mop_addr.push_back(ev);
        mop_line.push_back(m_line[w][i]);
      end
      mop_type.push_back(req_read);
      mop_addr.push_back({a[31:4], 4'b0000});
      mop_line.push_back('0);
      m_line[w][i]  = ref_mem[a[9:4]];
      m_tag[w][i]   = tg;
      m_valid[w][i] = 1'b1;
      m_dirty[w][i] = 1'b0;
    end
    if (t == req_write) begin
      m_line[w][i][32*ws +: 32] = d;
      m_dirty[w][i] = 1'b1;
    end
    m_lru[i] = ~w;
    exp_word.push_back(m_line[w][i][32*ws +: 32]);
    exp_hit.push_back(hit);
  endfunction

  // ------------------------------
  // memory model
  // ------------------------------
  logic mem_busy = 1'b0;
  int   mem_delay = 0;

  always @(posedge clk) begin
    if (reset) begin
      memreq_rdy  <= 1'b0;
      memresp_val <= 1'b0;
      mem_busy = 1'b0;
    end else if (mem_busy) begin
      if (memresp_val) begin
        if (memresp_rdy) begin
          memresp_val <= 1'b0;
          mem_busy = 1'b0;
        end
      end else if (mem_delay == 0) begin
        memresp_val <= 1'b1;
      end else begin
        mem_delay--;
      end
    end else if (memreq_val && memreq_rdy) begin
      if (mop_type.size() == 0) begin
        flag_error("memory request that the model did not expect");
      end else begin
        if (memreq_type !== mop_type[0]) begin
          flag_error("memory request of the wrong kind");
        end
        check_addr("memreq_addr", memreq_addr, mop_addr[0]);
        if (mop_type[0] == req_write) begin
          check_line("memreq_data", memreq_data, mop_line[0]);
        end
        void'(mop_type.pop_front());
        void'(mop_addr.pop_front());
        void'(mop_line.pop_front());
      end
      if (memreq_type == req_write) begin
        mem[memreq_addr[9:4]] = memreq_data;
        memresp_data <= '0;
      end else begin
        memresp_data <= mem[memreq_addr[9:4]];
      end
      memreq_rdy <= 1'b0;
      mem_busy = 1'b1;
      mem_delay = int'(take(2));
    end else begin
      memreq_rdy <= random_bit();
    end
  end

  // response back-pressure
  always @(posedge clk) begin
    cacheresp_rdy <= (reset || !stall) ? 1'b1 : random_bit();
  end

  // ------------------------------
  // response compare
  // ------------------------------
  int   cycle = 0;
  int   accept_cycle = 0;
  int   pending = 0;
  logic resp_seen = 1'b0;

  always @(posedge clk) begin
    if (!reset) begin
      if (cachereq_val && cachereq_rdy) begin
        if (pending != 0) begin
          flag_error("request accepted while a response was still pending");
        end
        model_access(cachereq_type, cachereq_addr, cachereq_data);
        pending++;
        accept_cycle = cycle;
        resp_seen = 1'b0;
      end
      if (cacheresp_val) begin
        if (exp_word.size() == 0) begin
          flag_error("response without a request");
        end else begin
          // a hit responds three cycles after acceptance
          if (!resp_seen && exp_hit[0] && cycle - accept_cycle != 3) begin
            flag_error("read hit latency is not 3 cycles");
          end
          resp_seen = 1'b1;
          check_word("cacheresp_data", cacheresp_data, exp_word[0]);
          if (cacheresp_rdy) begin
            void'(exp_word.pop_front());
            void'(exp_hit.pop_front());
            pending--;
          end
        end
      end
    end
    cycle++;
  end

  // ------------------------------
  // stimulus
  // ------------------------------
  task automatic send(input req_type_t t, input addr_t a, input word_t d);
    int n;
    cachereq_val  <= 1'b1;
    cachereq_type <= t;
    cachereq_addr <= a;
    cachereq_data <= d;
    n = 0;
    do begin
      @(posedge clk);
      n++;
    end while (!cachereq_rdy && n < 400);
    if (!cachereq_rdy) begin
      flag_error("request was not accepted in time");
    end
    cachereq_val <= 1'b0;
  endtask

  task automatic wait_idle;
    int n;
    n = 0;
    do begin
      @(posedge clk);
      n++;
    end while (!cachereq_rdy && n < 400);
    if (!cachereq_rdy) begin
      flag_error("response did not complete in time");
    end
  endtask

  task automatic send_random;
    logic [31:0] r;
    r = take(7);
    send(req_type_t'(random_bit()), {23'b0, r[6:0], 2'b00}, take(32));
  endtask

  initial begin
    clk = 1'b0;
    reset = 1'b1;
    cachereq_val = 1'b0;
    cachereq_type = req_read;
    cachereq_addr = '0;
    cachereq_data = '0;
    cacheresp_rdy = 1'b1;
    memreq_rdy = 1'b0;
    memresp_val = 1'b0;
    memresp_data = '0;
    m_lru = '0;
    for (int k = 0; k < 64; k++) begin
      mem[k] = fill_line(k);
      ref_mem[k] = fill_line(k);
    end
    for (int w = 0; w < 2; w++) begin
      for (int s = 0; s < 8; s++) begin
        m_valid[w][s] = 1'b0;
        m_dirty[w][s] = 1'b0;
        m_tag[w][s] = '0;
        m_line[w][s] = '0;
      end
    end
    repeat (5) @(posedge clk);
    reset <= 1'b0;
    @(posedge clk);
    check_cnt("cnt_req", cnt_req, '0);
    check_cnt("cnt_miss", cnt_miss, '0);
    if (cacheresp_val || memreq_val || memresp_rdy || !cachereq_rdy) begin
      flag_error("handshake outputs not at their reset values");
    end

    // cold reads, then write and read back
    send(req_read, 32'h0000_0044, '0);
    wait_idle();
    send(req_read, 32'h0000_0148, '0);
    wait_idle();
    send(req_write, 32'h0000_0048, 32'hdead_beef);
    wait_idle();
    send(req_read, 32'h0000_0048, '0);
    wait_idle();
    check_cnt("cnt_miss", cnt_miss, model_miss);

    // three tags in set 2 force dirty evictions
    send(req_write, 32'h0000_0020, 32'h1111_2222);
    wait_idle();
    send(req_write, 32'h0000_00a4, 32'h3333_4444);
    wait_idle();
    send(req_read, 32'h0000_0128, '0);
    wait_idle();
    send(req_read, 32'h0000_0020, '0);
    wait_idle();

    // random mix, then with response stalls and back-to-back requests
    repeat (200) begin
      send_random();
      wait_idle();
    end
    stall <= 1'b1;
    repeat (60) begin
      send_random();
    end
    wait_idle();
    stall <= 1'b0;

    check_cnt("cnt_req", cnt_req, model_req);
    check_cnt("cnt_miss", cnt_miss, model_miss);
    if (exp_word.size() != 0 || mop_type.size() != 0) begin
      flag_error("expected responses or memory requests left over");
    end
    $display("errors: %0d wrong values, %0d other failures", value_errors, other_errors);
    if (value_errors + other_errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

//--- hdl/cache_top.sv
// data cache top level
// joins the request controller with the tag store and the line store

`timescale 1ns/1ps

module cache_top import cache_pkg::*; (
  input  logic      clk,
  input  logic      reset,

  // processor side
  input  logic      cachereq_val,
  output logic      cachereq_rdy,
  input  req_type_t cachereq_type,
  input  addr_t     cachereq_addr,
  input  word_t     cachereq_data,

  output logic      cacheresp_val,
  input  logic      cacheresp_rdy,
  output word_t     cacheresp_data,

  // memory side
  output logic      memreq_val,
  input  logic      memreq_rdy,
  output req_type_t memreq_type,
  output addr_t     memreq_addr,
  output line_t     memreq_data,

  input  logic      memresp_val,
  output logic      memresp_rdy,
  input  line_t     memresp_data,

  // event counters
  output cnt_t      cnt_req,
  output cnt_t      cnt_miss
);

  addr_t req_addr;
  word_t req_data;

  logic  hit;
  way_t  hit_way;
  way_t  victim_way;
  logic  victim_dirty;
  tag_t  victim_tag;
  line_t victim_line;

  logic  access_en;
  way_t  access_way;
  logic  refill_en;
  logic  write_en;
  logic  clean_en;

  cache_ctrl cache_ctrl_i (
    .clk           (clk),
    .reset         (reset),
    .cachereq_val  (cachereq_val),
    .cachereq_rdy  (cachereq_rdy),
    .cachereq_type (cachereq_type),
    .cachereq_addr (cachereq_addr),
    .cachereq_data (cachereq_data),
    .cacheresp_val (cacheresp_val),
    .cacheresp_rdy (cacheresp_rdy),
    .memreq_val    (memreq_val),
    .memreq_rdy    (memreq_rdy),
    .memreq_type   (memreq_type),
    .memreq_addr   (memreq_addr),
    .memreq_data   (memreq_data),
    .memresp_val   (memresp_val),
    .memresp_rdy   (memresp_rdy),
    .cnt_req       (cnt_req),
    .cnt_miss      (cnt_miss),
    .req_addr      (req_addr),
    .req_data      (req_data),
    .hit           (hit),
    .hit_way       (hit_way),
    .victim_way    (victim_way),
    .victim_dirty  (victim_dirty),
    .victim_tag    (victim_tag),
    .victim_line   (victim_line),
    .access_en     (access_en),
    .access_way    (access_way),
    .refill_en     (refill_en),
    .write_en      (write_en),
    .clean_en      (clean_en)
  );

  cache_tags cache_tags_i (
    .clk          (clk),
    .reset        (reset),
    .req_addr     (req_addr),
    .access_en    (access_en),
    .access_way   (access_way),
    .refill_en    (refill_en),
    .write_en     (write_en),
    .clean_en     (clean_en),
    .hit          (hit),
    .hit_way      (hit_way),
    .victim_way   (victim_way),
    .victim_dirty (victim_dirty),
    .victim_tag   (victim_tag)
  );

  // response word comes straight from the store, held by the registered address
  cache_data cache_data_i (
    .clk       (clk),
    .req_addr  (req_addr),
    .req_data  (req_data),
    .refill_en (refill_en),
    .write_en  (write_en),
    .rd_way    (access_way),
    .line_in   (memresp_data),
    .word_out  (cacheresp_data),
    .line_out  (victim_line)
  );

endmodule

//--- hdl/cache_ctrl.sv
// blocking cache controller
// sequences tag check, eviction, refill and response for one request at a time

`timescale 1ns/1ps

module cache_ctrl import cache_pkg::*; (
  input  logic      clk,
  input  logic      reset,

  // processor side
  input  logic      cachereq_val,
  output logic      cachereq_rdy,
  input  req_type_t cachereq_type,
  input  addr_t     cachereq_addr,
  input  word_t     cachereq_data,
  output logic      cacheresp_val,
  input  logic      cacheresp_rdy,

  // memory side
  output logic      memreq_val,
  input  logic      memreq_rdy,
  output req_type_t memreq_type,
  output addr_t     memreq_addr,
  output line_t     memreq_data,
  input  logic      memresp_val,
  output logic      memresp_rdy,

  // counters
  output cnt_t      cnt_req,
  output cnt_t      cnt_miss,

  // registered request
  output addr_t     req_addr,
  output word_t     req_data,

  // from tag store and line store
  input  logic      hit,
  input  way_t      hit_way,
  input  way_t      victim_way,
  input  logic      victim_dirty,
  input  tag_t      victim_tag,
  input  line_t     victim_line,

  // strobes to the stores
  output logic      access_en,
  output way_t      access_way,
  output logic      refill_en,
  output logic      write_en,
  output logic      clean_en
);

  typedef enum logic [2:0] {
    idle,
    tag_check,
    evict_req,
    evict_wait,
    refill_req,
    refill_wait,
    access,
    respond
  } state_t;

  state_t    state;
  state_t    next_state;
  req_type_t req_type;
  index_t    req_index;

  logic      req_go;
  logic      miss_go;

  assign req_index = addr_index(req_addr);
  assign req_go    = (state == idle) && cachereq_val;
  assign miss_go   = (state == tag_check) && !hit;

  // ------------------------------
  // state register
  // ------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= idle;
    end else begin
      state <= next_state;
    end
  end

  always_comb begin
    next_state = state;
    case (state)
      idle: begin
        if (cachereq_val) begin
          next_state = tag_check;
        end
      end
      tag_check: begin
        if (hit) begin
          next_state = access;
        end else if (victim_dirty) begin
          next_state = evict_req;
        end else begin
          next_state = refill_req;
        end
      end
      evict_req: begin
        if (memreq_rdy) begin
          next_state = evict_wait;
        end
      end
      evict_wait: begin
        if (memresp_val) begin
          next_state = refill_req;
        end
      end
      refill_req: begin
        if (memreq_rdy) begin
          next_state = refill_wait;
        end
      end
      refill_wait: begin
        // after refill the line hits, so access applies a pending write
        if (memresp_val) begin
          next_state = access;
        end
      end
      access: begin
        next_state = respond;
      end
      respond: begin
        if (cacheresp_rdy) begin
          next_state = idle;
        end
      end
      default: begin
        next_state = idle;
      end
    endcase
  end

  // ------------------------------
  // request register
  // ------------------------------
  always_ff @(posedge clk) begin
    if (req_go) begin
      req_addr <= cachereq_addr;
      req_data <= cachereq_data;
      req_type <= cachereq_type;
    end
  end

  // ------------------------------
  // handshakes and strobes
  // ------------------------------
  assign cachereq_rdy  = (state == idle);
  assign cacheresp_val = (state == respond);

  assign memreq_val  = (state == evict_req) || (state == refill_req);
  assign memresp_rdy = (state == evict_wait) || (state == refill_wait);
  assign memreq_type = (state == evict_req) ? req_write : req_read;
  assign memreq_data = victim_line;

  // eviction goes to the victim's line, refill to the requested line
  assign memreq_addr = (state == evict_req) ? line_addr(victim_tag, req_index)
                                            : line_addr(addr_tag(req_addr), req_index);

  assign access_en = (state == access);
  assign write_en  = (state == access) && (req_type == req_write);
  assign refill_en = (state == refill_wait) && memresp_val;
  assign clean_en  = (state == evict_wait) && memresp_val;

  // hit way once the line is present, victim way while moving lines
  assign access_way = ((state == access) || (state == respond)) ? hit_way : victim_way;

  // ------------------------------
  // request and miss counters
  // ------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      cnt_req  <= '0;
      cnt_miss <= '0;
    end else begin
      if (req_go) begin
        cnt_req <= cnt_req + cnt_t'(1);
      end
      if (miss_go) begin
        cnt_miss <= cnt_miss + cnt_t'(1);
      end
    end
  end

endmodule

//--- hdl/cache_tags.sv
// cache tag store
// tags, valid, dirty and lru bits with hit detection and victim choice

`timescale 1ns/1ps

module cache_tags import cache_pkg::*; (
  input  logic  clk,
  input  logic  reset,

  input  addr_t req_addr,

  // update strobes
  input  logic  access_en,
  input  way_t  access_way,
  input  logic  refill_en,
  input  logic  write_en,
  input  logic  clean_en,

  // lookup results
  output logic  hit,
  output way_t  hit_way,
  output way_t  victim_way,
  output logic  victim_dirty,
  output tag_t  victim_tag
);

  tag_t                tags  [num_ways][num_sets];
  logic [num_sets-1:0] valid [num_ways];
  logic [num_sets-1:0] dirty [num_ways];

  // one bit per set, names the way to replace next
  logic [num_sets-1:0] lru;

  index_t              idx;
  tag_t                req_tag;
  logic [num_ways-1:0] match;

  assign idx     = addr_index(req_addr);
  assign req_tag = addr_tag(req_addr);

  // ------------------------------
  // lookup
  // ------------------------------
  always_comb begin
    for (int w = 0; w < num_ways; w++) begin
      match[w] = valid[w][idx] && (tags[w][idx] == req_tag);
    end
  end

  always_comb begin
    hit_way = '0;
    for (int w = 0; w < num_ways; w++) begin
      if (match[w]) begin
        hit_way = way_t'(w);
      end
    end
  end

  assign hit = |match;

  assign victim_way   = way_t'(lru[idx]);
  assign victim_dirty = valid[victim_way][idx] && dirty[victim_way][idx];
  assign victim_tag   = tags[victim_way][idx];

  // ------------------------------
  // tag array
  // ------------------------------
  // refill puts the request tag into the victim way
  always_ff @(posedge clk) begin
    if (refill_en) begin
      tags[victim_way][idx] <= req_tag;
    end
  end

  // ------------------------------
  // state bits
  // ------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int w = 0; w < num_ways; w++) begin
        valid[w] <= '0;
        dirty[w] <= '0;
      end
      lru <= '0;
    end else begin
      // fresh line arrives clean
      if (refill_en) begin
        valid[victim_way][idx] <= 1'b1;
        dirty[victim_way][idx] <= 1'b0;
      end
      // victim written back to memory
      if (clean_en) begin
        dirty[victim_way][idx] <= 1'b0;
      end
      if (write_en) begin
        dirty[access_way][idx] <= 1'b1;
      end
      // point lru at the way not just used
      if (access_en) begin
        lru[idx] <= ~access_way;
      end
    end
  end

endmodule

//--- hdl/cache_data.sv
// cache line store
// two ways of eight lines, line refill and single word write

`timescale 1ns/1ps

module cache_data import cache_pkg::*; (
  input  logic  clk,

  input  addr_t req_addr,
  input  word_t req_data,

  input  logic  refill_en,
  input  logic  write_en,
  input  way_t  rd_way,
  input  line_t line_in,

  output word_t word_out,
  output line_t line_out
);

  line_t     lines [num_ways][num_sets];

  index_t    idx;
  word_sel_t wsel;

  assign idx  = addr_index(req_addr);
  assign wsel = addr_word(req_addr);

  // ------------------------------
  // write port
  // ------------------------------
  // whole line on refill, one aligned word otherwise
  always_ff @(posedge clk) begin
    if (refill_en) begin
      lines[rd_way][idx] <= line_in;
    end else if (write_en) begin
      lines[rd_way][idx][32*wsel +: 32] <= req_data;
    end
  end

  // ------------------------------
  // read port
  // ------------------------------
  assign line_out = lines[rd_way][idx];
  assign word_out = line_out[32*wsel +: 32];

endmodule

//--- hdl/cache_pkg.sv
// cache package
// widths, address fields and request codes shared by the data cache blocks

package cache_pkg;

  // ------------------------------
  // widths
  // ------------------------------
  typedef logic [31:0]  addr_t;
  typedef logic [31:0]  word_t;
  typedef logic [127:0] line_t;
  typedef logic [24:0]  tag_t;
  typedef logic [2:0]   index_t;
  typedef logic [1:0]   word_sel_t;
  typedef logic [0:0]   way_t;
  typedef logic [9:0]   cnt_t;

  // request kind, same code on both ports
  typedef logic req_type_t;

  localparam req_type_t req_read  = 1'b0;
  localparam req_type_t req_write = 1'b1;

  // geometry: 256 bytes, 16-byte lines, two ways
  localparam int num_sets = 8;
  localparam int num_ways = 2;

  // ------------------------------
  // address fields
  // ------------------------------
  function automatic tag_t addr_tag(input addr_t addr);
    return addr[31:7];
  endfunction

  function automatic index_t addr_index(input addr_t addr);
    return addr[6:4];
  endfunction

  function automatic word_sel_t addr_word(input addr_t addr);
    return addr[3:2];
  endfunction

  // line-aligned byte address from its tag and set
  function automatic addr_t line_addr(input tag_t tag, input index_t index);
    return {tag, index, 4'b0000};
  endfunction

endpackage
